// ==== compile.f ====
design/noc_flit_pkg.sv
design/noc_topo_pkg.sv
design/input_port_ctrl.sv
design/output_allocator.sv
design/output_stage.sv
design/noc_router.sv
tests/noc_router_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := noc_router_tb
FILELIST := compile.f
BUILD    := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// ==== tests/router_vectors.txt ====
// router 5 sits at row 1, column 1 of the 4x4 torus
// columns (hex): input port, destination node, flit count, expected output port
// ports: 0 left, 1 right, 2 up, 3 down, 4 core
0 5 3 4   // local core
1 5 1 4   // single flit, same output as the line above
2 6 4 1   // next column, right
3 7 2 1   // two columns away, tie goes right
4 4 3 0   // column 0, negative difference wraps to left
0 0 2 0   // column 0 is handled before the row
1 9 3 3   // same column, next row down
2 d 1 3   // two rows away, tie goes down
4 1 2 2   // row 0, negative difference wraps to up
3 c 2 0   // row 3, column 0, column first
4 f 5 1   // row 3, column 3, column first
0 2 1 1   // row 0, column 2
1 8 2 0   // row 2, column 0
2 3 3 1   // row 0, column 3
3 5 2 4   // third packet into the core

// ==== tests/noc_router_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module noc_router_tb;

	localparam int np = noc_topo_pkg::num_ports;
	localparam logic [31:0] seed = 32'd39034;
	// source input rides in every flit, just below the markers
	localparam int src_lsb = 29;
	// stall phase sends 4 flits to core and 3 flits down
	localparam int stall_flits = 7;

	logic clk;
	logic rst;
	logic [np-1:0] in_req;
	logic [np-1:0] in_ack;
	noc_flit_pkg::flit_t in_flit [np];
	wire [np-1:0] out_req;
	wire [np-1:0] out_ack;
	wire noc_flit_pkg::flit_t out_flit [np];

	// flits waiting to enter, per input
	noc_flit_pkg::flit_t send_q [np][$];
	// flits expected out, indexed output * np + input
	noc_flit_pkg::flit_t exp_q [np*np][$];

	int vec_src [$];
	int vec_dst [$];
	int vec_len [$];
	int vec_port [$];

	logic [31:0] pay_rng;
	logic [np-1:0] stall_mask;
	int limit_cycles;

	// monitor state per output
	logic [np-1:0] hold_prev;
	logic [np-1:0] in_packet;
	noc_flit_pkg::flit_t held_flit [np];
	logic [2:0] owner [np];

	noc_router #(.router_id(5)) u_noc_router (
		.clk(clk),
		.rst(rst),
		.in_req_left(in_req[0]),
		.in_flit_left(in_flit[0]),
		.in_ack_left(in_ack[0]),
		.out_req_left(out_req[0]),
		.out_flit_left(out_flit[0]),
		.out_ack_left(out_ack[0]),
		.in_req_right(in_req[1]),
		.in_flit_right(in_flit[1]),
		.in_ack_right(in_ack[1]),
		.out_req_right(out_req[1]),
		.out_flit_right(out_flit[1]),
		.out_ack_right(out_ack[1]),
		.in_req_up(in_req[2]),
		.in_flit_up(in_flit[2]),
		.in_ack_up(in_ack[2]),
		.out_req_up(out_req[2]),
		.out_flit_up(out_flit[2]),
		.out_ack_up(out_ack[2]),
		.in_req_down(in_req[3]),
		.in_flit_down(in_flit[3]),
		.in_ack_down(in_ack[3]),
		.out_req_down(out_req[3]),
		.out_flit_down(out_flit[3]),
		.out_ack_down(out_ack[3]),
		.in_req_core(in_req[4]),
		.in_flit_core(in_flit[4]),
		.in_ack_core(in_ack[4]),
		.out_req_core(out_req[4]),
		.out_flit_core(out_flit[4]),
		.out_ack_core(out_ack[4])
	);

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
			input string what);
		if (got !== exp) begin
			$display("error %0t ns: %s (got %0h, expected %0h)", $time, what, got, exp);
			$display("** FAIL **");
			$fatal(1, "check failed");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "run aborted");
	endtask

	// builds one packet, queues it for sending and for the expected output
	task automatic make_packet(input int src, input int dst, input int len, input int port);
		noc_flit_pkg::flit_t f;
		for (int i = 0; i < len; i++) begin
			pay_rng = xorshift(pay_rng);
			f = '0;
			f[28:0] = pay_rng[28:0];
			f[src_lsb +: 3] = 3'(src);
			f[noc_flit_pkg::head_bit] = (i == 0);
			f[noc_flit_pkg::tail_bit] = (i == len - 1);
			// destination field only means something in the head
			if (i == 0)
				f[noc_flit_pkg::dst_lsb +: noc_flit_pkg::dst_w] = noc_flit_pkg::node_id_t'(dst);
			send_q[src].push_back(f);
			exp_q[port * np + src].push_back(f);
		end
	endtask

	function automatic int pending_count();
		int n;
		n = 0;
		for (int p = 0; p < np; p++)
			n += send_q[p].size();
		for (int k = 0; k < np * np; k++)
			n += exp_q[k].size();
		return n;
	endfunction

	// hold rule, then ordering and contiguity of every transferred flit
	task automatic check_outputs();
		noc_flit_pkg::flit_t f;
		int src;
		int k;
		for (int p = 0; p < np; p++) begin
			if (hold_prev[p]) begin
				check_value(64'(out_req[p]), 64'd1,
					$sformatf("out_req %0d dropped without in_ack", p));
				check_value(64'(out_flit[p]), 64'(held_flit[p]),
					$sformatf("out_flit %0d changed while stalled", p));
			end
			hold_prev[p] = out_req[p] && !in_ack[p];
			held_flit[p] = out_flit[p];
			if (out_req[p] && in_ack[p]) begin
				f = out_flit[p];
				src = int'(f[src_lsb +: 3]);
				check_value(64'(src < np), 64'd1,
					$sformatf("bad source field on output %0d", p));
				if (f[noc_flit_pkg::head_bit]) begin
					check_value(64'(in_packet[p]), 64'd0,
						$sformatf("head inside an open packet on output %0d", p));
					owner[p] = f[src_lsb +: 3];
				end else begin
					check_value(64'(in_packet[p]), 64'd1,
						$sformatf("body flit without head on output %0d", p));
				end
				// packets never interleave on one output
				check_value(64'(src), 64'(owner[p]),
					$sformatf("interleaved packets on output %0d", p));
				k = p * np + src;
				check_value(64'(exp_q[k].size() != 0), 64'd1,
					$sformatf("unexpected flit on output %0d from input %0d", p, src));
				check_value(64'(f), 64'(exp_q[k].pop_front()),
					$sformatf("flit on output %0d from input %0d", p, src));
				in_packet[p] = !f[noc_flit_pkg::tail_bit];
			end
		end
	endtask

	// ----------------------------------------
	// clock, links and monitor
	// ----------------------------------------
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// injectors for all five inputs plus random downstream ack
	initial begin : drive_links
		logic [np-1:0] took;
		logic [31:0] ack_rng;
		ack_rng = seed;
		in_req = '0;
		in_ack = '0;
		for (int p = 0; p < np; p++)
			in_flit[p] = '0;
		forever begin
			@(posedge clk);
			took = in_req & out_ack;
			@(negedge clk);
			for (int p = 0; p < np; p++) begin
				if (took[p])
					void'(send_q[p].pop_front());
				// flit stays put until it is taken
				if (send_q[p].size() != 0) begin
					in_req[p] = 1'b1;
					in_flit[p] = send_q[p][0];
				end else begin
					in_req[p] = 1'b0;
				end
				ack_rng = xorshift(ack_rng);
				in_ack[p] = !stall_mask[p] && (ack_rng[1:0] != 2'b00);
			end
		end
	end

	initial begin : watch_outputs
		hold_prev = '0;
		in_packet = '0;
		for (int p = 0; p < np; p++) begin
			held_flit[p] = '0;
			owner[p] = '0;
		end
		forever begin
			@(posedge clk);
			if (!rst)
				check_outputs();
		end
	end

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		abort_run($sformatf("timed out, traffic still pending after %0d cycles", limit_cycles));
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin : main_seq
		int fd;
		int a;
		int b;
		int c;
		int d;
		int total;
		string line;
		rst = 1'b1;
		pay_rng = seed;
		stall_mask = '0;
		limit_cycles = 0;

		fd = $fopen("tests/router_vectors.txt", "r");
		if (fd == 0)
			abort_run("cannot open tests/router_vectors.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// comment and blank lines give fewer than four fields
			if ($sscanf(line, "%h %h %h %h", a, b, c, d) == 4) begin
				if (a >= np || b > 15 || c < 1 || d >= np)
					abort_run({"malformed line in vector file: ", line});
				vec_src.push_back(a);
				vec_dst.push_back(b);
				vec_len.push_back(c);
				vec_port.push_back(d);
			end
		end
		$fclose(fd);
		if (vec_src.size() == 0)
			abort_run("vector file holds no packets");

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// idle router stays quiet
		repeat (3) begin
			@(posedge clk);
			check_value(64'(out_req), 64'd0, "out_req high before any flit");
			check_value(64'(out_ack), 64'd0, "out_ack high before any flit");
		end

		total = stall_flits;
		foreach (vec_len[i])
			total += vec_len[i];
		limit_cycles = total * 40 + 200;

		// all vector packets at once, so inputs contend
		foreach (vec_src[i])
			make_packet(vec_src[i], vec_dst[i], vec_len[i], vec_port[i]);
		while (pending_count() != 0)
			@(posedge clk);

		// core output stalled, left to core blocks, right to down must finish
		stall_mask = 5'b10000;
		make_packet(0, 5, 4, 4);
		make_packet(1, 9, 3, 3);
		while (exp_q[3 * np + 1].size() != 0)
			@(posedge clk);
		check_value(64'(out_req[4]), 64'd1, "stalled core output lost its flit");
		// only the head fits into the full core register
		check_value(64'(send_q[0].size()), 64'd3,
			"left input kept sending into the stalled core output");

		stall_mask = '0;
		while (pending_count() != 0)
			@(posedge clk);
		@(posedge clk);
		check_value(64'(out_req), 64'd0, "out_req high after all traffic");

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/noc_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module noc_router #(
	parameter int router_id = 0
) (
	input wire clk,
	input wire rst,
	// left side
	input wire in_req_left,
	input wire noc_flit_pkg::flit_t in_flit_left,
	input wire in_ack_left,
	output logic out_req_left,
	output noc_flit_pkg::flit_t out_flit_left,
	output logic out_ack_left,
	// right side
	input wire in_req_right,
	input wire noc_flit_pkg::flit_t in_flit_right,
	input wire in_ack_right,
	output logic out_req_right,
	output noc_flit_pkg::flit_t out_flit_right,
	output logic out_ack_right,
	// up side
	input wire in_req_up,
	input wire noc_flit_pkg::flit_t in_flit_up,
	input wire in_ack_up,
	output logic out_req_up,
	output noc_flit_pkg::flit_t out_flit_up,
	output logic out_ack_up,
	// down side
	input wire in_req_down,
	input wire noc_flit_pkg::flit_t in_flit_down,
	input wire in_ack_down,
	output logic out_req_down,
	output noc_flit_pkg::flit_t out_flit_down,
	output logic out_ack_down,
	// local core
	input wire in_req_core,
	input wire noc_flit_pkg::flit_t in_flit_core,
	input wire in_ack_core,
	output logic out_req_core,
	output noc_flit_pkg::flit_t out_flit_core,
	output logic out_ack_core
);

	localparam int np = noc_topo_pkg::num_ports;

	noc_topo_pkg::port_vec_t in_req_v;
	noc_topo_pkg::port_vec_t in_ack_v;
	noc_topo_pkg::port_vec_t out_req_v;
	noc_topo_pkg::port_vec_t out_ack_v;
	noc_topo_pkg::port_vec_t fire_v;
	noc_topo_pkg::port_vec_t tail_v;
	noc_topo_pkg::port_vec_t can_accept_v;
	noc_flit_pkg::flit_t in_flit_a [np];
	noc_flit_pkg::flit_t out_flit_a [np];

	// req_vec_a and grant_in indexed by input, req_col and grant_a by output
	noc_topo_pkg::port_vec_t req_vec_a [np];
	noc_topo_pkg::port_vec_t grant_in [np];
	noc_topo_pkg::port_vec_t req_col [np];
	noc_topo_pkg::port_vec_t grant_a [np];

	// ----------------------------------------
	// side ports to port codes
	// ----------------------------------------
	assign in_req_v = {in_req_core, in_req_down, in_req_up, in_req_right, in_req_left};
	assign in_ack_v = {in_ack_core, in_ack_down, in_ack_up, in_ack_right, in_ack_left};

	assign in_flit_a[noc_topo_pkg::port_left] = in_flit_left;
	assign in_flit_a[noc_topo_pkg::port_right] = in_flit_right;
	assign in_flit_a[noc_topo_pkg::port_up] = in_flit_up;
	assign in_flit_a[noc_topo_pkg::port_down] = in_flit_down;
	assign in_flit_a[noc_topo_pkg::port_core] = in_flit_core;

	assign {out_req_core, out_req_down, out_req_up, out_req_right, out_req_left} = out_req_v;
	assign {out_ack_core, out_ack_down, out_ack_up, out_ack_right, out_ack_left} = out_ack_v;

	assign out_flit_left = out_flit_a[noc_topo_pkg::port_left];
	assign out_flit_right = out_flit_a[noc_topo_pkg::port_right];
	assign out_flit_up = out_flit_a[noc_topo_pkg::port_up];
	assign out_flit_down = out_flit_a[noc_topo_pkg::port_down];
	assign out_flit_core = out_flit_a[noc_topo_pkg::port_core];

	// ----------------------------------------
	// per-port units and the crossbar wiring
	// ----------------------------------------
	for (genvar p = 0; p < np; p++) begin : g_port
		// transpose requests and grants between inputs and outputs
		for (genvar q = 0; q < np; q++) begin : g_xpose
			assign req_col[p][q] = req_vec_a[q][p];
			assign grant_in[p][q] = grant_a[q][p];
		end

		input_port_ctrl #(.router_id(router_id)) u_input_port_ctrl (
			.clk(clk),
			.rst(rst),
			.in_req(in_req_v[p]),
			.in_flit(in_flit_a[p]),
			.grant(grant_in[p]),
			.can_accept(can_accept_v),
			.out_ack(out_ack_v[p]),
			.req_vec(req_vec_a[p]),
			.fire(fire_v[p]),
			.tail_done(tail_v[p])
		);

		output_allocator u_output_allocator (
			.clk(clk),
			.rst(rst),
			.req_col(req_col[p]),
			.tail_done(tail_v),
			.grant(grant_a[p])
		);

		output_stage u_output_stage (
			.clk(clk),
			.rst(rst),
			.grant(grant_a[p]),
			.fire(fire_v),
			.flits(in_flit_a),
			.in_ack(in_ack_v[p]),
			.out_req(out_req_v[p]),
			.out_flit(out_flit_a[p]),
			.can_accept(can_accept_v[p])
		);
	end

endmodule

`default_nettype wire

// ==== design/output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_stage (
	input wire clk,
	input wire rst,
	input wire noc_topo_pkg::port_vec_t grant,
	input wire noc_topo_pkg::port_vec_t fire,
	input wire noc_flit_pkg::flit_t flits [noc_topo_pkg::num_ports],
	input wire in_ack,
	output logic out_req,
	output noc_flit_pkg::flit_t out_flit,
	output logic can_accept
);

	logic load;
	noc_flit_pkg::flit_t sel_flit;

	// ----------------------------------------
	// input select
	// ----------------------------------------
	// grant is one-hot, so a plain priority mux is enough
	always_comb begin
		sel_flit = '0;
		for (int k = 0; k < noc_topo_pkg::num_ports; k++) begin
			if (grant[k])
				sel_flit = flits[k];
		end
	end

	// owner transfers a flit this cycle
	assign load = |(grant & fire);

	// empty, or the downstream takes the flit now
	assign can_accept = !out_req || in_ack;

	// ----------------------------------------
	// one-flit register
	// ----------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			out_req <= 1'b0;
		else if (load)
			out_req <= 1'b1;
		else if (in_ack)
			out_req <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (load)
			out_flit <= sel_flit;
	end

	// downstream sees a stable flit until it acks
	a_hold_stable: assert property (@(posedge clk) disable iff (rst)
		out_req && !in_ack |=> out_req && $stable(out_flit));

	// input only fires into a register that can take it
	a_no_overrun: assert property (@(posedge clk) disable iff (rst)
		load |-> can_accept);

endmodule

`default_nettype wire

// ==== design/output_allocator.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_allocator (
	input wire clk,
	input wire rst,
	input wire noc_topo_pkg::port_vec_t req_col,
	input wire noc_topo_pkg::port_vec_t tail_done,
	output noc_topo_pkg::port_vec_t grant
);

	// search start, one past the last winner
	noc_topo_pkg::port_t ptr;

	noc_topo_pkg::port_vec_t pick;
	noc_topo_pkg::port_t win;
	logic found;
	int idx;

	// ----------------------------------------
	// round-robin choice
	// ----------------------------------------
	always_comb begin
		pick = '0;
		win = noc_topo_pkg::port_left;
		found = 1'b0;
		idx = 0;
		for (int k = 0; k < noc_topo_pkg::num_ports; k++) begin
			idx = (int'(ptr) + k) % noc_topo_pkg::num_ports;
			// first requester at or after the pointer
			if (!found && req_col[idx]) begin
				pick = '0;
				pick[idx] = 1'b1;
				win = noc_topo_pkg::port_t'(idx);
				found = 1'b1;
			end
		end
	end

	// ----------------------------------------
	// grant register
	// ----------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			grant <= '0;
			ptr <= noc_topo_pkg::port_left;
		end else if (grant != '0) begin
			// owner's tail leaves, output is free again
			if ((grant & tail_done) != '0)
				grant <= '0;
		end else if (found) begin
			grant <= pick;
			if (int'(win) == noc_topo_pkg::num_ports - 1)
				ptr <= noc_topo_pkg::port_left;
			else
				ptr <= win + noc_topo_pkg::port_t'(1);
		end
	end

	// at most one input owns the output
	a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(grant));

endmodule

`default_nettype wire

// ==== design/input_port_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_port_ctrl #(
	parameter int router_id = 0
) (
	input wire clk,
	input wire rst,
	input wire in_req,
	input wire noc_flit_pkg::flit_t in_flit,
	input wire noc_topo_pkg::port_vec_t grant,
	input wire noc_topo_pkg::port_vec_t can_accept,
	output logic out_ack,
	output noc_topo_pkg::port_vec_t req_vec,
	output logic fire,
	output logic tail_done
);

	// position of this node in the torus
	localparam int self_row = router_id / noc_topo_pkg::grid_dim;
	localparam int self_col = router_id % noc_topo_pkg::grid_dim;

	typedef enum logic {
		st_idle,
		st_fwd
	} state_t;

	state_t state;
	noc_topo_pkg::port_t route_q;
	noc_topo_pkg::port_t route_comb;
	noc_flit_pkg::node_id_t dst_id;
	int dst_row;
	int dst_col;
	int dif_row;
	int dif_col;
	logic head_req;

	// ----------------------------------------
	// route computation
	// ----------------------------------------
	always_comb begin
		dst_id = in_flit[noc_flit_pkg::dst_lsb +: noc_flit_pkg::dst_w];
		dst_row = int'(dst_id) / noc_topo_pkg::grid_dim;
		dst_col = int'(dst_id) % noc_topo_pkg::grid_dim;
		// forward distance around each ring
		dif_row = (noc_topo_pkg::grid_dim + dst_row - self_row) % noc_topo_pkg::grid_dim;
		dif_col = (noc_topo_pkg::grid_dim + dst_col - self_col) % noc_topo_pkg::grid_dim;
		// column first, then row, then core
		if (dif_row == 0 && dif_col == 0) begin
			route_comb = noc_topo_pkg::port_core;
		end else if (dif_col == 0) begin
			if (dif_row <= noc_topo_pkg::grid_dim / 2)
				route_comb = noc_topo_pkg::port_down;
			else
				route_comb = noc_topo_pkg::port_up;
		end else begin
			if (dif_col <= noc_topo_pkg::grid_dim / 2)
				route_comb = noc_topo_pkg::port_right;
			else
				route_comb = noc_topo_pkg::port_left;
		end
	end

	// ----------------------------------------
	// request and transfer control
	// ----------------------------------------
	// head waiting in idle asks for its output
	assign head_req = (state == st_idle) && in_req && in_flit[noc_flit_pkg::head_bit];

	always_comb begin
		req_vec = '0;
		if (head_req)
			req_vec[route_comb] = 1'b1;
	end

	// back-pressure straight from the owned output register
	assign out_ack = (state == st_fwd) && can_accept[route_q];
	assign fire = in_req && out_ack;
	assign tail_done = fire && in_flit[noc_flit_pkg::tail_bit];

	// packet state
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_idle;
			route_q <= noc_topo_pkg::port_left;
		end else begin
			case (state)
				st_idle: begin
					// grant seen, lock the route for the whole packet
					if (head_req && grant[route_comb]) begin
						state <= st_fwd;
						route_q <= route_comb;
					end
				end
				st_fwd: begin
					if (tail_done)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// no new request while a packet is in flight
	a_no_req_fwd: assert property (@(posedge clk) disable iff (rst)
		state == st_fwd |-> req_vec == '0);

	// the allocator keeps our grant for as long as we forward
	a_grant_held: assert property (@(posedge clk) disable iff (rst)
		state == st_fwd |-> grant[route_q]);

endmodule

`default_nettype wire

// ==== design/noc_topo_pkg.sv ====
`default_nettype none

// torus geometry and port numbering of one router
package noc_topo_pkg;

	// ----------------------------------------
	// torus size
	// ----------------------------------------
	// nodes per row and per column
	localparam int grid_dim = 4;

	// four neighbours plus the local core
	localparam int num_ports = 5;

	// ----------------------------------------
	// port codes
	// ----------------------------------------
	typedef logic [2:0] port_t;

	// same codes for inputs and outputs
	localparam port_t port_left = 3'd0;
	localparam port_t port_right = 3'd1;
	localparam port_t port_up = 3'd2;
	localparam port_t port_down = 3'd3;
	localparam port_t port_core = 3'd4;

	// one bit per port, indexed by the codes above
	typedef logic [num_ports-1:0] port_vec_t;

endpackage

`default_nettype wire

// ==== design/noc_flit_pkg.sv ====
`default_nettype none

// flit format shared by every link of the router
package noc_flit_pkg;

	// ----------------------------------------
	// widths and field positions
	// ----------------------------------------
	localparam int flit_w = 34;

	// packet markers, both set on a single-flit packet
	localparam int head_bit = 33;
	localparam int tail_bit = 32;

	// destination node, valid in head flits only
	localparam int dst_lsb = 24;
	localparam int dst_w = 4;

	// ----------------------------------------
	// types
	// ----------------------------------------
	typedef logic [flit_w-1:0] flit_t;
	typedef logic [dst_w-1:0] node_id_t;

endpackage

`default_nettype wire
